/* sha3_256_core.f */
+incdir+include
rtl/keccak_pkg.sv
rtl/block_loader.sv
rtl/round_constants.sv
rtl/keccak_round.sv
rtl/permutation_engine.sv
rtl/sha3_256_core.sv
sim/sha3_ref_pkg.sv
sim/sha3_tb.sv

/* Makefile */
VERILATOR = verilator
TOP       = sha3_tb
FILELIST  = sha3_256_core.f
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Some tests failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# A crash or a failed assertion also counts as a failing run
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/sha3_tb.sv */
`include "keccak_defines.svh"

module sha3_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int W       = `KECCAK_LANE_BITS;
    localparam int TIMEOUT = 200;
    localparam logic [255:0] KAT_EMPTY =
        256'ha7ffc6f8bf1ed76651c14756a061d662f580ff4de43b49fa82d80a4b80f8434a;
    localparam logic [255:0] KAT_ABC =
        256'h3a985da74fe225b2045c172d6bd390bd855f086e3e9d525b46bfe24511431532;

    logic                clk = 1'b0;
    logic                reset;
    logic                word_req;
    keccak_pkg::lane_t   word;
    logic                word_ack;
    keccak_pkg::digest_t digest;
    logic                digest_valid;
    logic                digest_ready;
    int                  mismatch_count = 0;
    int                  failure_count = 0;

    sha3_256_core DUT (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic finish_run();
        $display("Errors: %0d wrong values, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(string what);
        failure_count++;
        $display("Timeout after %0d cycles: %s", TIMEOUT, what);
        finish_run();
    endtask

    task automatic check_digest(string name, keccak_pkg::digest_t expected,
                                keccak_pkg::digest_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // Drive tasks
    //////////////////////////////////////////////////

    task automatic wait_ack(logic level);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_on_timeout("word_ack never reached the expected level");
            end
        end while (word_ack !== level);
    endtask

    task automatic send_word(keccak_pkg::lane_t value);
        @(posedge clk);
        word_req <= 1'b1;
        word     <= value;
        wait_ack(1'b1);
        @(posedge clk);
        word_req <= 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic send_message(sha3_ref_pkg::byte_q_t msg);
        keccak_pkg::block_t blk;
        blk = sha3_ref_pkg::pad_block(msg);
        for (int i = 0; i < `KECCAK_RATE_LANES; i++) begin
            send_word(blk[i*W +: W]);
        end
    endtask

    task automatic wait_digest(output keccak_pkg::digest_t value);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_on_timeout("digest_valid never rose");
            end
        end while (digest_valid !== 1'b1);
        value = digest;
        // Output handshake completes on the next edge
        if (digest_ready) begin
            @(posedge clk);
        end
    endtask

    function automatic sha3_ref_pkg::byte_q_t random_message();
        sha3_ref_pkg::byte_q_t msg;
        int                    len;
        len = $urandom_range(135, 0);
        repeat (len) msg.push_back(8'($urandom()));
        return msg;
    endfunction

    task automatic hash_and_check(string name, sha3_ref_pkg::byte_q_t msg);
        keccak_pkg::digest_t got;
        send_message(msg);
        wait_digest(got);
        check_digest(name, sha3_ref_pkg::digest_of(msg), got);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_empty_message();
        sha3_ref_pkg::byte_q_t msg;
        keccak_pkg::digest_t   got;
        check_digest("empty_model", sha3_ref_pkg::digest_from_fips(KAT_EMPTY),
                     sha3_ref_pkg::digest_of(msg));
        send_message(msg);
        wait_digest(got);
        check_digest("empty_message", sha3_ref_pkg::digest_from_fips(KAT_EMPTY), got);
    endtask

    task automatic test_abc_message();
        sha3_ref_pkg::byte_q_t msg;
        keccak_pkg::digest_t   got;
        msg.push_back(8'h61);
        msg.push_back(8'h62);
        msg.push_back(8'h63);
        send_message(msg);
        wait_digest(got);
        check_digest("abc_message", sha3_ref_pkg::digest_from_fips(KAT_ABC), got);
    endtask

    task automatic test_random_messages();
        repeat (10) hash_and_check("random_messages", random_message());
    endtask

    task automatic test_back_pressure();
        sha3_ref_pkg::byte_q_t m1;
        sha3_ref_pkg::byte_q_t m2;
        sha3_ref_pkg::byte_q_t m3;
        keccak_pkg::digest_t   first;
        keccak_pkg::digest_t   d1;
        keccak_pkg::digest_t   d2;
        keccak_pkg::digest_t   d3;
        keccak_pkg::block_t    blk3;
        m1   = random_message();
        m2   = random_message();
        m3   = random_message();
        blk3 = sha3_ref_pkg::pad_block(m3);
        @(posedge clk);
        digest_ready <= 1'b0;
        send_message(m1);
        wait_digest(first);
        send_message(m2);
        // Loader buffer now holds the second block
        @(posedge clk);
        word_req <= 1'b1;
        word     <= blk3[W-1:0];
        repeat (30) begin
            @(negedge clk);
            check_flag("back_pressure_ack", 1'b0, word_ack);
            check_flag("back_pressure_valid", 1'b1, digest_valid);
            check_digest("back_pressure_stable", first, digest);
        end
        fork
            send_message(m3);
            begin
                @(posedge clk);
                digest_ready <= 1'b1;
                wait_digest(d1);
                wait_digest(d2);
                wait_digest(d3);
            end
        join
        check_digest("back_pressure_first", sha3_ref_pkg::digest_of(m1), d1);
        check_digest("back_pressure_second", sha3_ref_pkg::digest_of(m2), d2);
        check_digest("back_pressure_third", sha3_ref_pkg::digest_of(m3), d3);
    endtask

    task automatic test_latency();
        sha3_ref_pkg::byte_q_t msg;
        keccak_pkg::block_t    blk;
        keccak_pkg::digest_t   got;
        int                    cycles;
        msg = random_message();
        blk = sha3_ref_pkg::pad_block(msg);
        for (int i = 0; i < `KECCAK_RATE_LANES - 1; i++) begin
            send_word(blk[i*W +: W]);
        end
        @(posedge clk);
        word_req <= 1'b1;
        word     <= blk[(`KECCAK_RATE_LANES-1)*W +: W];
        wait_ack(1'b1);
        // Count edges from the last lane's ack to digest_valid
        cycles = 0;
        do begin
            @(posedge clk);
            word_req <= 1'b0;
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("digest_valid never rose after the last lane");
            end
        end while (digest_valid !== 1'b1);
        got = digest;
        @(posedge clk);
        check_digest("latency_digest", sha3_ref_pkg::digest_of(msg), got);
        check_flag("latency_in_bounds", 1'b1, cycles >= 24 && cycles <= 27);
    endtask

    task automatic test_reset_mid_permutation();
        send_message(random_message());
        repeat (8) @(posedge clk);
        // First lane of the next message is acknowledged when reset hits
        word_req <= 1'b1;
        word     <= '0;
        wait_ack(1'b1);
        @(posedge clk);
        reset <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_flag("reset_held_digest_valid", 1'b0, digest_valid);
            check_flag("reset_held_word_ack", 1'b0, word_ack);
        end
        @(posedge clk);
        reset    <= 1'b1;
        word_req <= 1'b0;
        // The aborted permutation must never show a digest
        repeat (30) begin
            @(negedge clk);
            check_flag("reset_after_digest_valid", 1'b0, digest_valid);
            check_flag("reset_after_word_ack", 1'b0, word_ack);
        end
        hash_and_check("reset_recovery", random_message());
    endtask

    initial begin
        void'($urandom(8));
        reset        = 1'b0;
        word_req     = 1'b0;
        word         = '0;
        digest_ready = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        check_flag("after_reset_ack", 1'b0, word_ack);
        check_flag("after_reset_valid", 1'b0, digest_valid);
        test_empty_message();
        test_abc_message();
        test_random_messages();
        test_back_pressure();
        test_latency();
        test_reset_mid_permutation();
        finish_run();
    end

endmodule

/* sim/sha3_ref_pkg.sv */
`include "keccak_defines.svh"

package sha3_ref_pkg;

    localparam int W           = `KECCAK_LANE_BITS;
    localparam int RATE_BYTES  = `KECCAK_RATE_LANES * `KECCAK_LANE_BITS / 8;
    localparam int DIGEST_BITS = `KECCAK_DIGEST_LANES * `KECCAK_LANE_BITS;

    typedef logic [7:0] byte_q_t[$];

    function automatic keccak_pkg::lane_t rotl64(keccak_pkg::lane_t v, int n);
        int s;
        s = n % W;
        if (s == 0) begin
            return v;
        end
        return (v << s) | (v >> (W - s));
    endfunction

    // Offsets follow the (t+1)(t+2)/2 walk from lane (1, 0)
    function automatic int rho_offset(int x, int y);
        int cx;
        int cy;
        int nx;
        cx = 1;
        cy = 0;
        for (int t = 0; t < 24; t++) begin
            if (cx == x && cy == y) begin
                return ((t + 1) * (t + 2) / 2) % W;
            end
            nx = cy;
            cy = (2 * cx + 3 * cy) % 5;
            cx = nx;
        end
        return 0;
    endfunction

    // Round constant bits come from the x^8+x^6+x^5+x^4+1 LFSR
    function automatic keccak_pkg::lane_t iota_constant(int round);
        logic [7:0]        lfsr;
        keccak_pkg::lane_t rc;
        lfsr = 8'h01;
        rc   = '0;
        for (int j = 0; j <= round; j++) begin
            rc = '0;
            for (int i = 0; i < 7; i++) begin
                if (lfsr[0]) begin
                    rc[(1 << i) - 1] = 1'b1;
                end
                lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
            end
        end
        return rc;
    endfunction

    function automatic keccak_pkg::state_t keccak_f(keccak_pkg::state_t s);
        keccak_pkg::lane_t a [5][5];
        keccak_pkg::lane_t b [5][5];
        keccak_pkg::lane_t c [5];
        for (int i = 0; i < 25; i++) begin
            a[i % 5][i / 5] = s[i*W +: W];
        end
        for (int r = 0; r < `KECCAK_NUM_ROUNDS; r++) begin
            for (int x = 0; x < 5; x++) begin
                c[x] = a[x][0] ^ a[x][1] ^ a[x][2] ^ a[x][3] ^ a[x][4];
            end
            for (int i = 0; i < 25; i++) begin
                a[i % 5][i / 5] ^= c[(i % 5 + 4) % 5] ^ rotl64(c[(i % 5 + 1) % 5], 1);
            end
            for (int i = 0; i < 25; i++) begin
                b[i / 5][(2 * (i % 5) + 3 * (i / 5)) % 5] =
                    rotl64(a[i % 5][i / 5], rho_offset(i % 5, i / 5));
            end
            for (int i = 0; i < 25; i++) begin
                a[i % 5][i / 5] = b[i % 5][i / 5] ^
                    (~b[(i % 5 + 1) % 5][i / 5] & b[(i % 5 + 2) % 5][i / 5]);
            end
            a[0][0] ^= iota_constant(r);
        end
        for (int i = 0; i < 25; i++) begin
            s[i*W +: W] = a[i % 5][i / 5];
        end
        return s;
    endfunction

    // SHA3 domain bits 01 plus pad10*1, bytes packed little-endian
    function automatic keccak_pkg::block_t pad_block(byte_q_t msg);
        keccak_pkg::block_t blk;
        logic [7:0]         bytes [RATE_BYTES];
        for (int i = 0; i < RATE_BYTES; i++) begin
            bytes[i] = (i < msg.size()) ? msg[i] : 8'h00;
        end
        bytes[msg.size()]    = bytes[msg.size()] ^ 8'h06;
        bytes[RATE_BYTES-1]  = bytes[RATE_BYTES-1] | 8'h80;
        for (int i = 0; i < RATE_BYTES; i++) begin
            blk[8*i +: 8] = bytes[i];
        end
        return blk;
    endfunction

    function automatic keccak_pkg::digest_t digest_of(byte_q_t msg);
        keccak_pkg::state_t s;
        s = '0;
        s[$bits(keccak_pkg::block_t)-1:0] = pad_block(msg);
        s = keccak_f(s);
        return s[DIGEST_BITS-1:0];
    endfunction

    // FIPS hex strings list byte 0 first
    function automatic keccak_pkg::digest_t digest_from_fips(logic [DIGEST_BITS-1:0] hex);
        keccak_pkg::digest_t d;
        for (int k = 0; k < DIGEST_BITS / 8; k++) begin
            d[8*k +: 8] = hex[DIGEST_BITS-1-8*k -: 8];
        end
        return d;
    endfunction

endpackage

/* rtl/sha3_256_core.sv */
module sha3_256_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                word_req,
    input  keccak_pkg::lane_t   word,
    output logic                word_ack,
    output keccak_pkg::digest_t digest,
    output logic                digest_valid,
    input  logic                digest_ready
);

    // Loader to engine
    keccak_pkg::block_t block;
    logic               block_valid;
    logic               block_ready;

    block_loader u_block_loader (
        .clk         (clk),
        .reset       (reset),
        .word_req    (word_req),
        .word        (word),
        .word_ack    (word_ack),
        .block       (block),
        .block_valid (block_valid),
        .block_ready (block_ready)
    );

    permutation_engine u_permutation_engine (
        .clk          (clk),
        .reset        (reset),
        .block        (block),
        .block_valid  (block_valid),
        .block_ready  (block_ready),
        .digest       (digest),
        .digest_valid (digest_valid),
        .digest_ready (digest_ready)
    );

endmodule

/* rtl/permutation_engine.sv */
`include "keccak_defines.svh"

module permutation_engine (
    input  logic                clk,
    input  logic                reset,
    input  keccak_pkg::block_t  block,
    input  logic                block_valid,
    output logic                block_ready,
    output keccak_pkg::digest_t digest,
    output logic                digest_valid,
    input  logic                digest_ready
);

    localparam int DIGEST_BITS = `KECCAK_DIGEST_LANES * `KECCAK_LANE_BITS;
    localparam keccak_pkg::round_idx_t LAST_ROUND =
        keccak_pkg::round_idx_t'(`KECCAK_NUM_ROUNDS - 1);

    keccak_pkg::perm_state_e fsm_q;
    keccak_pkg::round_idx_t  round_q;
    keccak_pkg::state_t      state_q;
    keccak_pkg::state_t      round_out;
    keccak_pkg::lane_t       round_const;
    logic                    accept;

    assign block_ready  = (fsm_q == keccak_pkg::PERM_IDLE);
    assign accept       = block_valid && block_ready;
    assign digest_valid = (fsm_q == keccak_pkg::PERM_HOLD);
    assign digest       = state_q[DIGEST_BITS-1:0];

    round_constants u_round_constants (
        .round    (round_q),
        .constant (round_const)
    );

    keccak_round u_keccak_round (
        .state_in  (state_q),
        .constant  (round_const),
        .state_out (round_out)
    );

    //////////////////////////////////////////////////
    // Control FSM and round counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            fsm_q   <= keccak_pkg::PERM_IDLE;
            round_q <= '0;
        end else begin
            case (fsm_q)
                keccak_pkg::PERM_IDLE: begin
                    if (accept) begin
                        fsm_q   <= keccak_pkg::PERM_RUN;
                        round_q <= '0;
                    end
                end
                keccak_pkg::PERM_RUN: begin
                    if (round_q == LAST_ROUND) begin
                        fsm_q <= keccak_pkg::PERM_HOLD;
                    end else begin
                        round_q <= round_q + 5'd1;
                    end
                end
                keccak_pkg::PERM_HOLD: begin
                    if (digest_ready) begin
                        fsm_q <= keccak_pkg::PERM_IDLE;
                    end
                end
                default: fsm_q <= keccak_pkg::PERM_IDLE;
            endcase
        end
    end

    // Single block absorb, capacity lanes start at zero
    always_ff @(posedge clk) begin
        if (accept) begin
            state_q <= keccak_pkg::state_t'(block);
        end else if (fsm_q == keccak_pkg::PERM_RUN) begin
            state_q <= round_out;
        end
    end

    a_round_range: assert property (@(posedge clk) disable iff (!reset)
        (fsm_q == keccak_pkg::PERM_RUN) |-> (round_q < `KECCAK_NUM_ROUNDS));

    // No second block until all rounds are done and the digest is up
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!reset)
        accept |=> (!accept) [*`KECCAK_NUM_ROUNDS] ##1 (digest_valid && !accept));

    a_digest_hold: assert property (@(posedge clk) disable iff (!reset)
        (digest_valid && !digest_ready) |=> (digest_valid && $stable(digest)));

endmodule

/* rtl/keccak_round.sv */
`include "keccak_defines.svh"

module keccak_round (
    input  keccak_pkg::state_t state_in,
    input  keccak_pkg::lane_t  constant,
    output keccak_pkg::state_t state_out
);

    localparam int W     = `KECCAK_LANE_BITS;
    localparam int LANES = `KECCAK_STATE_LANES;

    // Rho offsets, indexed by lane x + 5y
    localparam int RHO [LANES] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    keccak_pkg::lane_t a [LANES];
    keccak_pkg::lane_t t [LANES];
    keccak_pkg::lane_t b [LANES];
    keccak_pkg::lane_t e [LANES];
    keccak_pkg::lane_t c [5];
    keccak_pkg::lane_t d [5];

    function automatic keccak_pkg::lane_t rotl(keccak_pkg::lane_t v, int n);
        if (n == 0) begin
            return v;
        end
        return (v << n) | (v >> (W - n));
    endfunction

    //////////////////////////////////////////////////
    // Theta
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            a[i] = state_in[i*W +: W];
        end
        // Column parities
        for (int x = 0; x < 5; x++) begin
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        end
        for (int x = 0; x < 5; x++) begin
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
        end
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                t[x+5*y] = a[x+5*y] ^ d[x];
            end
        end
    end

    //////////////////////////////////////////////////
    // Rho and pi
    //////////////////////////////////////////////////

    // Lane (x, y) moves to (y, 2x + 3y), so destination (X, Y)
    // reads source x = (X + 3Y) mod 5, y = X
    always_comb begin
        for (int yd = 0; yd < 5; yd++) begin
            for (int xd = 0; xd < 5; xd++) begin
                b[xd+5*yd] = rotl(t[((xd+3*yd)%5) + 5*xd], RHO[((xd+3*yd)%5) + 5*xd]);
            end
        end
    end

    //////////////////////////////////////////////////
    // Chi and iota
    //////////////////////////////////////////////////

    always_comb begin
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                e[x+5*y] = b[x+5*y] ^ (~b[((x+1)%5)+5*y] & b[((x+2)%5)+5*y]);
            end
        end
        // Round constant into lane (0, 0) only
        e[0] = e[0] ^ constant;
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            state_out[i*W +: W] = e[i];
        end
    end

endmodule

/* rtl/round_constants.sv */
module round_constants (
    input  keccak_pkg::round_idx_t round,
    output keccak_pkg::lane_t      constant
);

    // Iota constants for Keccak-f[1600]
    always_comb begin
        case (round)
            5'd0:    constant = 64'h0000_0000_0000_0001;
            5'd1:    constant = 64'h0000_0000_0000_8082;
            5'd2:    constant = 64'h8000_0000_0000_808A;
            5'd3:    constant = 64'h8000_0000_8000_8000;
            5'd4:    constant = 64'h0000_0000_0000_808B;
            5'd5:    constant = 64'h0000_0000_8000_0001;
            5'd6:    constant = 64'h8000_0000_8000_8081;
            5'd7:    constant = 64'h8000_0000_0000_8009;
            5'd8:    constant = 64'h0000_0000_0000_008A;
            5'd9:    constant = 64'h0000_0000_0000_0088;
            5'd10:   constant = 64'h0000_0000_8000_8009;
            5'd11:   constant = 64'h0000_0000_8000_000A;
            5'd12:   constant = 64'h0000_0000_8000_808B;
            5'd13:   constant = 64'h8000_0000_0000_008B;
            5'd14:   constant = 64'h8000_0000_0000_8089;
            5'd15:   constant = 64'h8000_0000_0000_8003;
            5'd16:   constant = 64'h8000_0000_0000_8002;
            5'd17:   constant = 64'h8000_0000_0000_0080;
            5'd18:   constant = 64'h0000_0000_0000_800A;
            5'd19:   constant = 64'h8000_0000_8000_000A;
            5'd20:   constant = 64'h8000_0000_8000_8081;
            5'd21:   constant = 64'h8000_0000_0000_8080;
            5'd22:   constant = 64'h0000_0000_8000_0001;
            5'd23:   constant = 64'h8000_0000_8000_8008;
            // Past the last round
            default: constant = 64'h0000_0000_0000_0000;
        endcase
    end

endmodule

/* rtl/block_loader.sv */
`include "keccak_defines.svh"

module block_loader (
    input  logic               clk,
    input  logic               reset,
    input  logic               word_req,
    input  keccak_pkg::lane_t  word,
    output logic               word_ack,
    output keccak_pkg::block_t block,
    output logic               block_valid,
    input  logic               block_ready
);

    localparam int LANE_BITS  = `KECCAK_LANE_BITS;
    localparam int BLOCK_BITS = `KECCAK_RATE_LANES * `KECCAK_LANE_BITS;
    localparam logic [4:0] LAST_LANE = 5'(`KECCAK_RATE_LANES - 1);

    keccak_pkg::load_state_e state_q;
    logic [4:0]              lane_cnt;
    logic                    take_word;
    logic                    transfer;

    // Only collecting state has room for a word
    assign take_word = (state_q == keccak_pkg::LOAD_COLLECT) && word_req;
    assign transfer  = block_valid && block_ready;

    //////////////////////////////////////////////////
    // Four-phase handshake FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state_q     <= keccak_pkg::LOAD_COLLECT;
            lane_cnt    <= '0;
            word_ack    <= 1'b0;
            block_valid <= 1'b0;
        end else begin
            if (transfer) begin
                block_valid <= 1'b0;
            end
            case (state_q)
                keccak_pkg::LOAD_COLLECT: begin
                    if (take_word) begin
                        word_ack <= 1'b1;
                        state_q  <= keccak_pkg::LOAD_WAIT_LOW;
                        if (lane_cnt == LAST_LANE) begin
                            lane_cnt    <= '0;
                            block_valid <= 1'b1;
                        end else begin
                            lane_cnt <= lane_cnt + 5'd1;
                        end
                    end
                end
                keccak_pkg::LOAD_WAIT_LOW: begin
                    if (!word_req) begin
                        word_ack <= 1'b0;
                        // Buffer stays closed until the engine takes it
                        if (block_valid && !transfer) begin
                            state_q <= keccak_pkg::LOAD_FULL;
                        end else begin
                            state_q <= keccak_pkg::LOAD_COLLECT;
                        end
                    end
                end
                keccak_pkg::LOAD_FULL: begin
                    if (transfer) begin
                        state_q <= keccak_pkg::LOAD_COLLECT;
                    end
                end
                default: state_q <= keccak_pkg::LOAD_COLLECT;
            endcase
        end
    end

    // Shift in from the top, so the first word lands in lane 0
    always_ff @(posedge clk) begin
        if (take_word) begin
            block <= {word, block[BLOCK_BITS-1:LANE_BITS]};
        end
    end

    a_ack_after_req: assert property (@(posedge clk) disable iff (!reset)
        $rose(word_ack) |-> $past(word_req));

endmodule

/* rtl/keccak_pkg.sv */
`include "keccak_defines.svh"

package keccak_pkg;

    //////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////

    // One 64-bit lane
    typedef logic [`KECCAK_LANE_BITS-1:0] lane_t;

    // Full state, lane x + 5y at bit 64 * (x + 5y)
    typedef logic [`KECCAK_STATE_LANES*`KECCAK_LANE_BITS-1:0] state_t;

    // One rate block, lane 0 in the low bits
    typedef logic [`KECCAK_RATE_LANES*`KECCAK_LANE_BITS-1:0] block_t;

    // Digest lanes, lane 0 in the low bits
    typedef logic [`KECCAK_DIGEST_LANES*`KECCAK_LANE_BITS-1:0] digest_t;

    // Round number, 0 to 23 in use
    typedef logic [4:0] round_idx_t;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////

    // Block loader
    typedef enum logic [1:0] {
        LOAD_COLLECT  = 2'd0,
        LOAD_WAIT_LOW = 2'd1,
        LOAD_FULL     = 2'd2
    } load_state_e;

    // Permutation engine
    typedef enum logic [1:0] {
        PERM_IDLE = 2'd0,
        PERM_RUN  = 2'd1,
        PERM_HOLD = 2'd2
    } perm_state_e;

endpackage

/* include/keccak_defines.svh */
`ifndef KECCAK_DEFINES_SVH
`define KECCAK_DEFINES_SVH

//////////////////////////////////////////////////
// Keccak-f[1600] geometry
//////////////////////////////////////////////////

// Width of one lane in bits
`define KECCAK_LANE_BITS 64

// Lanes in the full 5x5 state
`define KECCAK_STATE_LANES 25

//////////////////////////////////////////////////
// SHA3-256 sponge parameters
//////////////////////////////////////////////////

// Rate of 1088 bits, as lanes
`define KECCAK_RATE_LANES 17

// Digest of 256 bits, as lanes
`define KECCAK_DIGEST_LANES 4

// Rounds per permutation
`define KECCAK_NUM_ROUNDS 24

`endif
